// File: source/sync_long_pkg.sv
package sync_long_pkg;

    // one complex sample, i in the upper half
    typedef struct packed {
        logic signed [15:0] i;
        logic signed [15:0] q;
    } sample_t;

    typedef logic [15:0] sample_idx_t;  // running sample count, wraps

    typedef struct packed {
        logic [31:0] mag;               // |I| + |Q| of the correlation
        sample_idx_t idx;               // newest sample in the window
    } metric_t;

    typedef enum logic [2:0] {
        st_skipping,
        st_first_peak,
        st_second_peak,
        st_idle,
        st_symbols
    } sync_state_e;

    typedef struct packed {
        sample_t    data;
        logic [7:0] symbol;             // 0 and 1 are the training symbols
        logic       sof;
        logic       eof;
    } framed_sample_t;

    localparam int lts_taps     = 16;
    localparam int sts_tail_len = 32;
    localparam int peak_window  = 64;
    localparam int symbol_len   = 64;
    localparam int gi_long      = 16;
    localparam int gi_short     = 8;
    localparam int gap_min      = 63;
    localparam int gap_max      = 65;

    // first 16 samples of the long training symbol
    localparam sample_t lts_ref [lts_taps] = '{
        '{ 16'sd156,    16'sd0},
        '{-16'sd5,      16'sd120},
        '{ 16'sd40,     16'sd111},
        '{ 16'sd97,    -16'sd83},
        '{ 16'sd21,    -16'sd28},
        '{ 16'sd60,     16'sd88},
        '{-16'sd115,    16'sd55},
        '{-16'sd38,     16'sd106},
        '{ 16'sd98,     16'sd26},
        '{ 16'sd53,    -16'sd4},
        '{ 16'sd1,      16'sd115},
        '{-16'sd137,    16'sd47},
        '{ 16'sd24,     16'sd59},
        '{ 16'sd59,     16'sd15},
        '{-16'sd22,    -16'sd161},
        '{ 16'sd119,    16'sd4}
    };

endpackage

// File: source/sample_buffer.sv
module sample_buffer #(
    parameter int buf_addr_w = 8
) (
    input  logic                      clock,
    input  logic                      reset,
    input  sync_long_pkg::sample_t     wr_data_i,
    input  logic                      wr_stb_i,
    output sync_long_pkg::sample_idx_t wr_idx_o,
    input  sync_long_pkg::sample_idx_t rd_idx_i,
    output sync_long_pkg::sample_t     rd_data_o
);
    import sync_long_pkg::*;

    localparam int depth = 1 << buf_addr_w;

    sample_t     mem [depth];
    sample_idx_t wr_idx;                // index the next sample gets

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_idx <= '0;
        end else if (wr_stb_i) begin
            wr_idx <= wr_idx + 16'd1;
        end
    end

    always_ff @(posedge clock) begin
        if (wr_stb_i) begin
            mem[wr_idx[buf_addr_w-1:0]] <= wr_data_i;
        end
        rd_data_o <= mem[rd_idx_i[buf_addr_w-1:0]];  // one cycle read latency
    end

    assign wr_idx_o = wr_idx;

endmodule

// File: source/lts_correlator.sv
module lts_correlator (
    input  logic                      clock,
    input  logic                      reset,
    input  sync_long_pkg::sample_t     sample_i,
    input  logic                      sample_stb_i,
    input  sync_long_pkg::sample_idx_t sample_idx_i,
    output sync_long_pkg::metric_t     metric_o,
    output logic                      metric_stb_o
);
    import sync_long_pkg::*;

    sample_t            win      [lts_taps];  // win[lts_taps-1] is the newest
    sample_t            win_next [lts_taps];
    logic signed [31:0] prod_i   [lts_taps];
    logic signed [31:0] prod_q   [lts_taps];
    logic               prod_stb;
    sample_idx_t        prod_idx;
    logic signed [31:0] sum_i;
    logic signed [31:0] sum_q;
    logic        [31:0] abs_i;
    logic        [31:0] abs_q;

    // window as it stands once the incoming sample is shifted in
    always_comb begin
        for (int k = 0; k < lts_taps - 1; k++) begin
            win_next[k] = win[k+1];
        end
        win_next[lts_taps-1] = sample_i;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int k = 0; k < lts_taps; k++) begin
                win[k] <= '0;           // zeros before the first sample
            end
        end else if (sample_stb_i) begin
            win <= win_next;
        end
    end

    // stage 1, x times conj(ref)
    always_ff @(posedge clock) begin
        for (int k = 0; k < lts_taps; k++) begin
            prod_i[k] <= win_next[k].i * lts_ref[k].i + win_next[k].q * lts_ref[k].q;
            prod_q[k] <= win_next[k].q * lts_ref[k].i - win_next[k].i * lts_ref[k].q;
        end
        prod_idx <= sample_idx_i;
    end

    always_comb begin
        sum_i = '0;
        sum_q = '0;
        for (int k = 0; k < lts_taps; k++) begin
            sum_i = sum_i + prod_i[k];
            sum_q = sum_q + prod_q[k];
        end
        abs_i = (sum_i < 0) ? 32'(-sum_i) : 32'(sum_i);
        abs_q = (sum_q < 0) ? 32'(-sum_q) : 32'(sum_q);
    end

    // stage 2, magnitude and index
    always_ff @(posedge clock) begin
        metric_o.mag <= abs_i + abs_q;
        metric_o.idx <= prod_idx;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            prod_stb     <= 1'b0;
            metric_stb_o <= 1'b0;
        end else begin
            prod_stb     <= sample_stb_i;
            metric_stb_o <= prod_stb;
        end
    end

endmodule

// File: source/peak_search.sv
module peak_search (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       sample_stb_i,
    input  sync_long_pkg::metric_t      metric_i,
    input  logic                       metric_stb_i,
    output logic                       found_o,
    output sync_long_pkg::sample_idx_t  start_idx_o,
    output sync_long_pkg::sync_state_e  state_o
);
    import sync_long_pkg::*;

    logic [6:0]  count;                 // tail samples, then metrics per window
    logic [31:0] max1;
    logic [31:0] max2;
    sample_idx_t idx1;
    sample_idx_t idx2;
    logic        new_max1;
    logic        new_max2;
    logic        last_metric;
    sample_idx_t peak2_idx;
    sample_idx_t gap;
    logic        gap_ok;

    // strictly greater so the earliest maximum wins a tie
    assign new_max1    = metric_stb_i && (metric_i.mag > max1);
    assign new_max2    = metric_stb_i && (metric_i.mag > max2);
    assign last_metric = metric_stb_i && (count == 7'(peak_window - 1));

    // the last metric of window 2 may itself be the second peak
    assign peak2_idx = new_max2 ? metric_i.idx : idx2;
    assign gap       = peak2_idx - idx1;
    assign gap_ok    = (gap >= 16'(gap_min)) && (gap <= 16'(gap_max));

    always_ff @(posedge clock) begin
        if (reset) begin
            state_o     <= st_skipping;
            count       <= '0;
            max1        <= '0;
            max2        <= '0;
            idx1        <= '0;
            idx2        <= '0;
            found_o     <= 1'b0;
            start_idx_o <= '0;
        end else begin
            found_o <= 1'b0;
            case (state_o)
                st_skipping: begin
                    if (sample_stb_i) begin
                        if (count == 7'(sts_tail_len - 1)) begin
                            count   <= '0;
                            state_o <= st_first_peak;
                        end else begin
                            count <= count + 7'd1;
                        end
                    end
                end

                st_first_peak: begin
                    if (new_max1) begin
                        max1 <= metric_i.mag;
                        idx1 <= metric_i.idx;
                    end
                    if (last_metric) begin
                        count   <= '0;
                        state_o <= st_second_peak;
                    end else if (metric_stb_i) begin
                        count <= count + 7'd1;
                    end
                end

                st_second_peak: begin
                    if (new_max2) begin
                        max2 <= metric_i.mag;
                        idx2 <= metric_i.idx;
                    end
                    if (last_metric) begin
                        count <= '0;
                        if (gap_ok) begin
                            found_o     <= 1'b1;
                            start_idx_o <= idx1 - 16'(lts_taps - 1);  // oldest in window
                            state_o     <= st_symbols;
                        end else begin
                            state_o <= st_idle;   // wait for reset
                        end
                    end else if (metric_stb_i) begin
                        count <= count + 7'd1;
                    end
                end

                st_idle, st_symbols: begin
                    state_o <= state_o;     // held until reset
                end

                default: begin
                    state_o <= st_skipping;
                end
            endcase
        end
    end

endmodule

// File: source/symbol_framer.sv
module symbol_framer #(
    parameter int buf_addr_w = 8
) (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       found_i,
    input  sync_long_pkg::sample_idx_t  start_idx_i,
    input  sync_long_pkg::sample_idx_t  wr_idx_i,
    input  logic                       short_gi_i,
    output sync_long_pkg::sample_idx_t  rd_idx_o,
    input  sync_long_pkg::sample_t      rd_data_i,
    output sync_long_pkg::framed_sample_t out_o,
    output logic                       out_stb_o
);
    import sync_long_pkg::*;

    logic                    active;    // set once the preamble is found
    logic                    loading;   // reading a symbol out
    sample_idx_t             rd_idx;
    logic [5:0]              offset;    // position within the symbol
    logic [7:0]              sym_cnt;
    logic signed [buf_addr_w:0] lead;
    logic                    start_sym;
    logic                    last_in_sym;
    sample_idx_t             gi_skip;
    logic                    tag_stb;
    logic                    tag_sof;
    logic                    tag_eof;
    logic [7:0]              tag_sym;

    // the writer never legally runs more than one buffer depth ahead
    assign lead = wr_idx_i[buf_addr_w:0] - rd_idx[buf_addr_w:0];

    assign start_sym   = active && !loading && (lead >= symbol_len);
    assign last_in_sym = loading && (offset == 6'(symbol_len - 1));
    assign gi_skip     = short_gi_i ? 16'(gi_short) : 16'(gi_long);

    always_ff @(posedge clock) begin
        if (reset) begin
            active  <= 1'b0;
            loading <= 1'b0;
            rd_idx  <= '0;
            offset  <= '0;
            sym_cnt <= '0;
        end else if (found_i) begin
            active  <= 1'b1;
            loading <= 1'b0;
            rd_idx  <= start_idx_i;
            offset  <= '0;
            sym_cnt <= '0;
        end else if (start_sym) begin
            loading <= 1'b1;
            offset  <= '0;
        end else if (loading) begin
            offset <= offset + 6'd1;
            if (last_in_sym) begin
                loading <= 1'b0;
                sym_cnt <= sym_cnt + 8'd1;
                // training symbols are back to back, data symbols skip the gi
                if (sym_cnt != 8'd0) begin
                    rd_idx <= rd_idx + 16'd1 + gi_skip;
                end else begin
                    rd_idx <= rd_idx + 16'd1;
                end
            end else begin
                rd_idx <= rd_idx + 16'd1;
            end
        end
    end

    // tags trail the address by the buffer read latency
    always_ff @(posedge clock) begin
        if (reset) begin
            tag_stb <= 1'b0;
            tag_sof <= 1'b0;
            tag_eof <= 1'b0;
            tag_sym <= '0;
        end else begin
            tag_stb <= loading;
            tag_sof <= loading && (offset == 6'd0);
            tag_eof <= last_in_sym;
            tag_sym <= sym_cnt;
        end
    end

    assign rd_idx_o     = rd_idx;
    assign out_o.data   = rd_data_i;
    assign out_o.symbol = tag_sym;
    assign out_o.sof    = tag_sof;
    assign out_o.eof    = tag_eof;
    assign out_stb_o    = tag_stb;

endmodule

// File: source/sync_long_top.sv
module sync_long_top #(
    parameter int buf_addr_w = 8
) (
    input  logic                         clock,
    input  logic                         reset,
    input  sync_long_pkg::sample_t        sample_i,
    input  logic                         sample_stb_i,
    input  logic                         short_gi_i,
    output sync_long_pkg::metric_t        metric_o,
    output logic                         metric_stb_o,
    output logic                         found_o,
    output sync_long_pkg::sync_state_e    state_o,
    output sync_long_pkg::framed_sample_t out_o,
    output logic                         out_stb_o
);
    import sync_long_pkg::*;

    sample_idx_t wr_idx;                // shared time base
    sample_idx_t rd_idx;
    sample_t     rd_data;
    sample_idx_t start_idx;

    sample_buffer #(
        .buf_addr_w(buf_addr_w)
    ) u_buffer (
        .clock    (clock),
        .reset    (reset),
        .wr_data_i(sample_i),
        .wr_stb_i (sample_stb_i),
        .wr_idx_o (wr_idx),
        .rd_idx_i (rd_idx),
        .rd_data_o(rd_data)
    );

    lts_correlator u_correlator (
        .clock       (clock),
        .reset       (reset),
        .sample_i    (sample_i),
        .sample_stb_i(sample_stb_i),
        .sample_idx_i(wr_idx),           // index this sample is written to
        .metric_o    (metric_o),
        .metric_stb_o(metric_stb_o)
    );

    peak_search u_peak_search (
        .clock       (clock),
        .reset       (reset),
        .sample_stb_i(sample_stb_i),
        .metric_i    (metric_o),
        .metric_stb_i(metric_stb_o),
        .found_o     (found_o),
        .start_idx_o (start_idx),
        .state_o     (state_o)
    );

    symbol_framer #(
        .buf_addr_w(buf_addr_w)
    ) u_framer (
        .clock      (clock),
        .reset      (reset),
        .found_i    (found_o),
        .start_idx_i(start_idx),
        .wr_idx_i   (wr_idx),
        .short_gi_i (short_gi_i),
        .rd_idx_o   (rd_idx),
        .rd_data_i  (rd_data),
        .out_o      (out_o),
        .out_stb_o  (out_stb_o)
    );

endmodule

// File: test/tb_sync_long_sva.sv
module tb_sync_long_sva (
    input logic                          clock,
    input logic                          reset,
    input logic                          sample_stb_i,
    input logic                          metric_stb_o,
    input logic                          found_o,
    input sync_long_pkg::sync_state_e    state_o,
    input sync_long_pkg::framed_sample_t out_o,
    input logic                          out_stb_o
);
    import sync_long_pkg::*;

    found_pulse: assert property (@(posedge clock) disable iff (reset)
        found_o |=> !found_o)
        else $error("found_o stayed high for more than one cycle");

    // correlator pipeline is two stages deep
    metric_after_sample: assert property (@(posedge clock) disable iff (reset)
        sample_stb_i |-> ##2 metric_stb_o)
        else $error("no metric strobe two cycles after a sample strobe");

    metric_has_sample: assert property (@(posedge clock) disable iff (reset)
        metric_stb_o |-> $past(sample_stb_i, 2))
        else $error("metric strobe without a sample strobe two cycles before");

    out_in_symbols: assert property (@(posedge clock) disable iff (reset)
        out_stb_o |-> (state_o == st_symbols))
        else $error("output strobe outside st_symbols");

    eof_strobed: assert property (@(posedge clock) disable iff (reset)
        out_o.eof |-> out_stb_o)
        else $error("eof tag on a sample that is not strobed");

endmodule

bind sync_long_top tb_sync_long_sva sva_checks (
    .clock       (clock),
    .reset       (reset),
    .sample_stb_i(sample_stb_i),
    .metric_stb_o(metric_stb_o),
    .found_o     (found_o),
    .state_o     (state_o),
    .out_o       (out_o),
    .out_stb_o   (out_stb_o)
);

// File: test/tb_sync_long.sv
module tb_sync_long;
    import sync_long_pkg::*;

    localparam int n_short       = 200;     // ends after the training symbols
    localparam int n_long        = 400;     // carries data symbols too
    localparam int total_samples = 6 * n_short + 2 * n_long;
    // at most 3 cycles per sample, reset and drain per stream, 20 percent margin
    localparam int max_cycles    = (total_samples * 3 + 8 * 160) * 12 / 10;

    logic           clock;
    logic           reset;
    sample_t        sample_i;
    logic           sample_stb_i;
    logic           short_gi_i;
    metric_t        metric_o;
    logic           metric_stb_o;
    logic           found_o;
    sync_state_e    state_o;
    framed_sample_t out_o;
    logic           out_stb_o;

    sample_t        smp [n_long];           // stimulus by sample index
    int             idle [n_long];          // idle cycles before each strobe
    int             n_smp;
    logic [31:0]    exp_mag [n_long];
    logic [31:0]    exp_max1;
    logic [31:0]    exp_max2;
    sample_idx_t    exp_idx1;
    sample_idx_t    exp_idx2;
    logic           exp_found;
    sample_idx_t    exp_start;
    metric_t        met_q [$];
    framed_sample_t out_q [$];
    framed_sample_t exp_q [$];
    int             found_cnt;
    int             errors;
    int             tests_passed;
    int             tests_failed;
    int             cycles = 0;

    sync_long_top #(
        .buf_addr_w(8)
    ) UUT (
        .clock       (clock),
        .reset       (reset),
        .sample_i    (sample_i),
        .sample_stb_i(sample_stb_i),
        .short_gi_i  (short_gi_i),
        .metric_o    (metric_o),
        .metric_stb_o(metric_stb_o),
        .found_o     (found_o),
        .state_o     (state_o),
        .out_o       (out_o),
        .out_stb_o   (out_stb_o)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: tests still running after %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clock) begin
        if (!reset) begin
            if (metric_stb_o) begin
                met_q.push_back(metric_o);
            end
            if (out_stb_o) begin
                out_q.push_back(out_o);
            end
            if (found_o) begin
                found_cnt++;
            end
        end
    end

    task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("ERROR at %0t: %s, expected %0h, got %0h", $time, what, exp, act);
            errors++;
        end
    endtask

    function automatic sample_t rand_sample();
        sample_t s;
        s.i = 16'(int'($urandom_range(63)) - 32);  // small next to the reference
        s.q = 16'(int'($urandom_range(63)) - 32);
        return s;
    endfunction

    task automatic apply_reset();
        @(posedge clock);
        reset        <= 1'b1;
        sample_stb_i <= 1'b0;
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        met_q.delete();
        out_q.delete();
        found_cnt = 0;
    endtask

    // training symbol at p1 and p2, a negative position leaves it out
    task automatic build_stream(input int n, input int p1, input int p2, input bit quiet);
        sample_t lts [symbol_len];
        for (int k = 0; k < symbol_len; k++) begin
            lts[k] = (k < lts_taps) ? lts_ref[k] : rand_sample();  // padded with noise
        end
        n_smp = n;
        for (int j = 0; j < n; j++) begin
            smp[j]  = quiet ? '0 : rand_sample();
            idle[j] = $urandom_range(2);
        end
        for (int k = 0; k < symbol_len; k++) begin
            if (p1 >= 0) begin
                smp[p1 + k] = lts[k];
            end
            if (p2 >= 0) begin
                smp[p2 + k] = lts[k];
            end
        end
    endtask

    task automatic run_model(input int gi);
        int             si;
        int             sq;
        int             xi;
        int             xq;
        int             n0;
        int             s;
        int             k;
        sample_idx_t    gap;
        framed_sample_t f;
        for (int n = 0; n < n_smp; n++) begin
            si = 0;
            sq = 0;
            for (int t = 0; t < lts_taps; t++) begin
                xi = (n - lts_taps + 1 + t >= 0) ? int'(smp[n - lts_taps + 1 + t].i) : 0;
                xq = (n - lts_taps + 1 + t >= 0) ? int'(smp[n - lts_taps + 1 + t].q) : 0;
                si += xi * int'(lts_ref[t].i) + xq * int'(lts_ref[t].q);
                sq += xq * int'(lts_ref[t].i) - xi * int'(lts_ref[t].q);
            end
            exp_mag[n] = 32'((si < 0 ? -si : si) + (sq < 0 ? -sq : sq));
        end
        // metric of sample 30 still lands in window 1 when sample 31 follows directly
        n0 = (idle[sts_tail_len - 1] == 0) ? sts_tail_len - 2 : sts_tail_len - 1;
        exp_max1 = '0;
        exp_max2 = '0;
        exp_idx1 = '0;
        exp_idx2 = '0;
        for (int j = 0; j < peak_window; j++) begin
            if (exp_mag[n0 + j] > exp_max1) begin
                exp_max1 = exp_mag[n0 + j];
                exp_idx1 = 16'(n0 + j);
            end
            if (exp_mag[n0 + peak_window + j] > exp_max2) begin
                exp_max2 = exp_mag[n0 + peak_window + j];
                exp_idx2 = 16'(n0 + peak_window + j);
            end
        end
        gap       = exp_idx2 - exp_idx1;
        exp_found = (gap >= 16'(gap_min)) && (gap <= 16'(gap_max));
        exp_start = exp_idx1 - 16'(lts_taps - 1);
        exp_q.delete();
        s = int'(exp_start);
        k = 0;
        while (exp_found && (s + symbol_len <= n_smp)) begin
            for (int j = 0; j < symbol_len; j++) begin
                f.data   = smp[s + j];
                f.symbol = 8'(k);
                f.sof    = (j == 0);
                f.eof    = (j == symbol_len - 1);
                exp_q.push_back(f);
            end
            s = s + symbol_len + ((k >= 1) ? gi : 0);  // no gi between the training symbols
            k++;
        end
    endtask

    task automatic drive_stream();
        for (int j = 0; j < n_smp; j++) begin
            repeat (idle[j]) begin
                @(posedge clock);
                sample_stb_i <= 1'b0;
            end
            @(posedge clock);
            sample_i     <= smp[j];
            sample_stb_i <= 1'b1;
        end
        @(posedge clock);
        sample_stb_i <= 1'b0;
    endtask

    task automatic run_stream(input int n, input int p1, input int p2, input bit quiet,
                              input bit short_gi);
        apply_reset();
        short_gi_i <= short_gi;
        build_stream(n, p1, p2, quiet);
        run_model(short_gi ? gi_short : gi_long);
        drive_stream();
        @(negedge clock);
        while (state_o != st_idle && state_o != st_symbols) begin
            @(negedge clock);           // search is over in either end state
        end
        @(posedge clock);               // the monitor has seen the found pulse by now
    endtask

    task automatic check_frames();
        while (out_q.size() < exp_q.size()) begin
            @(posedge clock);
        end
        for (int j = 0; j < exp_q.size(); j++) begin
            check_val($sformatf("output sample %0d", j), exp_q[j], out_q[j]);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d mismatches", name, errors - errors_before);
        end
    endtask

    task automatic test_metric_values();
        int e0;
        e0 = errors;
        run_stream(n_short, 48, 112, 1'b0, 1'b0);
        while (met_q.size() < n_smp) begin
            @(posedge clock);
        end
        for (int j = 0; j < n_smp; j++) begin
            check_val($sformatf("metric %0d magnitude", j), exp_mag[j], met_q[j].mag);
            check_val($sformatf("metric %0d index", j), 16'(j), met_q[j].idx);
        end
        finish_test("metric values", e0);
    endtask

    task automatic test_detection();
        int e0;
        e0 = errors;
        run_stream(n_short, 48, 112, 1'b0, 1'b0);
        check_val("model finds the preamble", 1, exp_found);
        check_val("first peak index", 48 + lts_taps - 1, exp_idx1);
        check_val("second peak index", 112 + lts_taps - 1, exp_idx2);
        check_val("first peak metric", exp_max1, met_q[exp_idx1].mag);
        check_val("second peak metric", exp_max2, met_q[exp_idx2].mag);
        check_val("found pulses", 1, found_cnt);
        check_val("state after detection", st_symbols, state_o);
        finish_test("detection", e0);
    endtask

    task automatic test_rejection();
        int e0;
        e0 = errors;
        for (int run = 0; run < 2; run++) begin
            if (run == 0) begin
                run_stream(n_short, 48, 128, 1'b0, 1'b0);  // spacing of 80
            end else begin
                run_stream(n_short, 100, -1, 1'b1, 1'b0);  // one training symbol
            end
            check_val("model rejects the gap", 0, exp_found);
            check_val("found pulses", 0, found_cnt);
            check_val("state after rejection", st_idle, state_o);
            check_val("output samples seen", 0, out_q.size());
        end
        finish_test("rejection", e0);
    endtask

    task automatic test_guard(input bit short_gi);
        int e0;
        e0 = errors;
        run_stream(n_long, 48, 112, 1'b0, short_gi);
        check_val("found pulses", 1, found_cnt);
        check_frames();
        finish_test(short_gi ? "short guard interval" : "long guard interval", e0);
    endtask

    task automatic test_reset_midstream();
        int e0;
        e0 = errors;
        run_stream(n_short, 48, 112, 1'b0, 1'b0);
        while (out_q.size() == 0) begin
            @(posedge clock);
        end
        apply_reset();
        check_val("state after reset", st_skipping, state_o);
        check_val("metric strobe after reset", 0, metric_stb_o);
        check_val("found after reset", 0, found_o);
        check_val("output strobe after reset", 0, out_stb_o);
        run_stream(n_short, 48, 112, 1'b0, 1'b0);
        check_val("found pulses after reset", 1, found_cnt);
        check_val("state after new preamble", st_symbols, state_o);
        check_frames();
        finish_test("reset mid-stream", e0);
    endtask

    initial begin
        void'($urandom(32'hbc4d_22d9));
        reset        = 1'b1;
        sample_i     = '0;
        sample_stb_i = 1'b0;
        short_gi_i   = 1'b0;
        found_cnt    = 0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        test_metric_values();
        test_detection();
        test_rejection();
        test_guard(1'b0);
        test_guard(1'b1);
        test_reset_midstream();
        $display("tests passed %0d, tests failed %0d, mismatches %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
source/sync_long_pkg.sv
source/sample_buffer.sv
source/lts_correlator.sv
source/peak_search.sv
source/symbol_framer.sv
source/sync_long_top.sv
test/tb_sync_long_sva.sv
test/tb_sync_long.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module tb_sync_long -o tb_sync_long
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sync_long > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation completed successfully" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
